// File: design/alu_pkg.sv
// shared definitions of the integer execution unit
// width constants, operand word and operation encoding,
// request and response structs.

`default_nettype none

package alu_pkg;

    localparam int XLEN   = 64;  // rv64 data width.
    localparam int WORD_W = 32;  // width of the W forms.
    localparam int TAG_W  = 4;   // opaque request tag.

    typedef logic [XLEN-1:0] bus64_t;

    // all operations handled by the unit
    typedef enum logic [4:0] {
        ADD,
        SUB,
        ADDW,
        SUBW,
        SLT,
        SLTU,
        AND,
        OR,
        XOR,
        ANDN,
        ORN,
        XNOR,
        SLL,
        SRL,
        SRA,
        SLLW,
        SRLW,
        SRAW,
        SLLIUW,
        ROL,
        ROR,
        ROLW,
        RORW
    } instr_type_t;

    typedef struct packed {
        instr_type_t      instr_type;
        bus64_t           data_rs1;
        bus64_t           data_rs2;  // already muxed with the immediate.
        logic [TAG_W-1:0] tag;
    } alu_req_t;

    typedef struct packed {
        bus64_t           result;
        logic [TAG_W-1:0] tag;
    } alu_resp_t;

endpackage

`default_nettype wire

// File: design/alu_shift.sv
// shifts and rotations of the execution unit
// one left, one logical-right and one arithmetic-right shifter,
// rotations merged through a mask from the arithmetic shifter.

`timescale 1ns/100ps
`default_nettype none

module alu_shift (
    input  alu_pkg::bus64_t      data_rs1_i,
    input  alu_pkg::bus64_t      data_rs2_i,
    input  alu_pkg::instr_type_t instr_type_i,
    output alu_pkg::bus64_t      result_o
);

    logic [6:0]      shamt;
    logic            is_word_rot;
    logic [6:0]      rot_width;
    logic [6:0]      sll_amt;
    logic [6:0]      srl_amt;
    logic [6:0]      sra_amt;
    logic [64:0]     sra_data;
    logic [64:0]     sra_wide;
    alu_pkg::bus64_t operand;
    alu_pkg::bus64_t res_sll;
    alu_pkg::bus64_t res_srl;
    alu_pkg::bus64_t res_sra;
    alu_pkg::bus64_t rot_mask;

    assign is_word_rot = (instr_type_i == alu_pkg::ROLW) || (instr_type_i == alu_pkg::RORW);
    assign rot_width   = is_word_rot ? 7'd32 : 7'd64;

    // W forms only look at five bits of rs2
    always_comb begin
        case (instr_type_i)
            alu_pkg::SLLW, alu_pkg::SRLW, alu_pkg::SRAW,
            alu_pkg::ROLW, alu_pkg::RORW: shamt = {2'b0, data_rs2_i[4:0]};
            default:                      shamt = {1'b0, data_rs2_i[5:0]};
        endcase
    end

    always_comb begin
        case (instr_type_i)
            alu_pkg::SRLW, alu_pkg::SLLIUW, alu_pkg::ROLW, alu_pkg::RORW: begin
                operand = {{(alu_pkg::XLEN-alu_pkg::WORD_W){1'b0}},
                           data_rs1_i[alu_pkg::WORD_W-1:0]};  // zero-extend low word.
            end
            alu_pkg::SRAW: begin
                operand = {{(alu_pkg::XLEN-alu_pkg::WORD_W){data_rs1_i[alu_pkg::WORD_W-1]}},
                           data_rs1_i[alu_pkg::WORD_W-1:0]};  // sign-extend low word.
            end
            default: begin
                operand = data_rs1_i;
            end
        endcase
    end

    // rotations use complementary amounts on the two shifters
    always_comb begin
        case (instr_type_i)
            alu_pkg::ROL, alu_pkg::ROLW: begin
                sll_amt = shamt;
                srl_amt = rot_width - shamt;
            end
            alu_pkg::ROR, alu_pkg::RORW: begin
                sll_amt = rot_width - shamt;
                srl_amt = shamt;
            end
            default: begin
                sll_amt = shamt;
                srl_amt = shamt;
            end
        endcase
    end

    always_comb begin
        case (instr_type_i)
            alu_pkg::ROL, alu_pkg::ROR, alu_pkg::ROLW, alu_pkg::RORW: begin
                sra_data = {1'b1, {alu_pkg::XLEN{1'b0}}};  // lone sign bit for the mask.
                sra_amt  = is_word_rot ? srl_amt + 7'd32 : srl_amt;
            end
            default: begin
                sra_data = {operand[alu_pkg::XLEN-1], operand};
                sra_amt  = shamt;
            end
        endcase
    end

    assign res_sll  = operand << sll_amt;
    assign res_srl  = operand >> srl_amt;
    assign sra_wide = $signed(sra_data) >>> sra_amt;
    assign res_sra  = sra_wide[alu_pkg::XLEN-1:0];

    // ones mark the bits taken from the left shifter.
    assign rot_mask = is_word_rot ?
                      {{(alu_pkg::XLEN-alu_pkg::WORD_W){1'b0}}, res_sra[alu_pkg::WORD_W-1:0]} :
                      res_sra;

    always_comb begin
        case (instr_type_i)
            alu_pkg::SLL, alu_pkg::SLLW, alu_pkg::SLLIUW: result_o = res_sll;
            alu_pkg::SRL, alu_pkg::SRLW:                  result_o = res_srl;
            alu_pkg::SRA, alu_pkg::SRAW:                  result_o = res_sra;
            alu_pkg::ROL, alu_pkg::ROR, alu_pkg::ROLW, alu_pkg::RORW: begin
                result_o = (res_sll & rot_mask) | (res_srl & ~rot_mask);
            end
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/alu_arith.sv
// adder and comparator of the execution unit
// shared add/subtract, signed and unsigned set-less-than.

`timescale 1ns/100ps
`default_nettype none

module alu_arith (
    input  alu_pkg::bus64_t      data_rs1_i,
    input  alu_pkg::bus64_t      data_rs2_i,
    input  alu_pkg::instr_type_t instr_type_i,
    output alu_pkg::bus64_t      result_o
);

    logic            is_sub;
    alu_pkg::bus64_t operand_b;
    logic [64:0]     sum;
    logic            lt_signed;
    logic            lt_unsigned;

    // compares run as a subtraction too
    always_comb begin
        case (instr_type_i)
            alu_pkg::SUB, alu_pkg::SUBW,
            alu_pkg::SLT, alu_pkg::SLTU: is_sub = 1'b1;
            default:                     is_sub = 1'b0;
        endcase
    end

    assign operand_b = is_sub ? ~data_rs2_i : data_rs2_i;
    assign sum       = {1'b0, data_rs1_i} + {1'b0, operand_b} + {64'b0, is_sub};

    assign lt_unsigned = ~sum[64];  // no carry means rs1 below rs2.
    assign lt_signed   = (data_rs1_i[63] ^ data_rs2_i[63]) ? data_rs1_i[63] : sum[63];

    always_comb begin
        case (instr_type_i)
            alu_pkg::ADD, alu_pkg::SUB,
            alu_pkg::ADDW, alu_pkg::SUBW: result_o = sum[63:0];  // W extended later.
            alu_pkg::SLT:                 result_o = {63'b0, lt_signed};
            alu_pkg::SLTU:                result_o = {63'b0, lt_unsigned};
            default:                      result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/alu_bitwise.sv
// bitwise logic of the execution unit
// and, or, xor and the inverted-operand forms.

`timescale 1ns/100ps
`default_nettype none

module alu_bitwise (
    input  alu_pkg::bus64_t      data_rs1_i,
    input  alu_pkg::bus64_t      data_rs2_i,
    input  alu_pkg::instr_type_t instr_type_i,
    output alu_pkg::bus64_t      result_o
);

    logic            invert_b;
    alu_pkg::bus64_t operand_b;

    always_comb begin
        case (instr_type_i)
            alu_pkg::ANDN, alu_pkg::ORN, alu_pkg::XNOR: invert_b = 1'b1;
            default:                                    invert_b = 1'b0;
        endcase
    end

    assign operand_b = invert_b ? ~data_rs2_i : data_rs2_i;

    // xnor is xor against the inverted operand.
    always_comb begin
        case (instr_type_i)
            alu_pkg::AND, alu_pkg::ANDN: result_o = data_rs1_i & operand_b;
            alu_pkg::OR, alu_pkg::ORN:   result_o = data_rs1_i | operand_b;
            alu_pkg::XOR, alu_pkg::XNOR: result_o = data_rs1_i ^ operand_b;
            default:                     result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/alu_result_stage.sv
// output stage of the execution unit
// result select by class, word sign-extension,
// one-entry response register with valid/ready handshake,
// handshake and request assertions.

`timescale 1ns/100ps
`default_nettype none

module alu_result_stage (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  alu_pkg::instr_type_t      instr_type_i,
    input  logic [alu_pkg::TAG_W-1:0] tag_i,
    input  alu_pkg::bus64_t           res_shift_i,
    input  alu_pkg::bus64_t           res_arith_i,
    input  alu_pkg::bus64_t           res_bitwise_i,
    output logic                      resp_valid_o,
    input  logic                      resp_ready_i,
    output alu_pkg::alu_resp_t        resp_o
);

    alu_pkg::bus64_t    sel_result;
    alu_pkg::bus64_t    ext_result;
    alu_pkg::alu_resp_t resp_q;
    logic               valid_q;
    logic               accept;

    always_comb begin
        case (instr_type_i)
            alu_pkg::ADD, alu_pkg::SUB, alu_pkg::ADDW, alu_pkg::SUBW,
            alu_pkg::SLT, alu_pkg::SLTU: sel_result = res_arith_i;
            alu_pkg::AND, alu_pkg::OR, alu_pkg::XOR,
            alu_pkg::ANDN, alu_pkg::ORN, alu_pkg::XNOR: sel_result = res_bitwise_i;
            alu_pkg::SLL, alu_pkg::SRL, alu_pkg::SRA, alu_pkg::SLLW, alu_pkg::SRLW,
            alu_pkg::SRAW, alu_pkg::SLLIUW, alu_pkg::ROL, alu_pkg::ROR,
            alu_pkg::ROLW, alu_pkg::RORW: sel_result = res_shift_i;
            default: sel_result = '0;
        endcase
    end

    // W results carry bit 31 up. sllIUW stays zero-extended
    always_comb begin
        case (instr_type_i)
            alu_pkg::ADDW, alu_pkg::SUBW, alu_pkg::SLLW, alu_pkg::SRLW,
            alu_pkg::SRAW, alu_pkg::ROLW, alu_pkg::RORW: begin
                ext_result = {{(alu_pkg::XLEN-alu_pkg::WORD_W){sel_result[alu_pkg::WORD_W-1]}},
                              sel_result[alu_pkg::WORD_W-1:0]};
            end
            default: begin
                ext_result = sel_result;
            end
        endcase
    end

    assign req_ready_o = ~valid_q | resp_ready_i;  // free now or drained this cycle.
    assign accept      = req_valid_i & req_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (resp_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            resp_q.result <= ext_result;
            resp_q.tag    <= tag_i;
        end
    end

    assign resp_valid_o = valid_q;
    assign resp_o       = resp_q;

    // a stalled response must not move.
    resp_stable_a: assert property (
        @(posedge clk_i) disable iff (reset_i)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o)
    ) else $error("response changed while held by downstream.");

    // only the 23 defined encodings may come with a request.
    known_op_a: assert property (
        @(posedge clk_i) disable iff (reset_i)
        req_valid_i |-> instr_type_i <= alu_pkg::RORW
    ) else $error("request carries an undefined operation.");

endmodule

`default_nettype wire

// File: design/alu_top.sv
// top of the integer execution unit
// shift, arithmetic and bitwise blocks feeding the output stage.

`timescale 1ns/100ps
`default_nettype none

module alu_top (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  alu_pkg::alu_req_t  req_i,
    output logic               resp_valid_o,
    input  logic               resp_ready_i,
    output alu_pkg::alu_resp_t resp_o
);

    alu_pkg::bus64_t res_shift;
    alu_pkg::bus64_t res_arith;
    alu_pkg::bus64_t res_bitwise;

    alu_shift shift0 (
        .data_rs1_i   (req_i.data_rs1),
        .data_rs2_i   (req_i.data_rs2),
        .instr_type_i (req_i.instr_type),
        .result_o     (res_shift)
    );

    alu_arith arith0 (
        .data_rs1_i   (req_i.data_rs1),
        .data_rs2_i   (req_i.data_rs2),
        .instr_type_i (req_i.instr_type),
        .result_o     (res_arith)
    );

    alu_bitwise bitwise0 (
        .data_rs1_i   (req_i.data_rs1),
        .data_rs2_i   (req_i.data_rs2),
        .instr_type_i (req_i.instr_type),
        .result_o     (res_bitwise)
    );

    alu_result_stage result0 (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .instr_type_i  (req_i.instr_type),
        .tag_i         (req_i.tag),
        .res_shift_i   (res_shift),
        .res_arith_i   (res_arith),
        .res_bitwise_i (res_bitwise),
        .resp_valid_o  (resp_valid_o),
        .resp_ready_i  (resp_ready_i),
        .resp_o        (resp_o)
    );

endmodule

`default_nettype wire

// File: test/tb_alu_model.svh
// reference model of the execution unit
// expected result of one request, from the RV64 instruction rules.

`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

function automatic alu_pkg::bus64_t sext_word(input logic [31:0] w);
    return {{32{w[31]}}, w};
endfunction

function automatic alu_pkg::bus64_t model_result(input alu_pkg::alu_req_t req);
    logic [63:0] a;
    logic [63:0] b;
    logic [31:0] aw;
    logic [6:0]  sh;
    logic [5:0]  shw;
    a   = req.data_rs1;
    b   = req.data_rs2;
    aw  = a[31:0];
    sh  = {1'b0, b[5:0]};  // full-width amount.
    shw = {1'b0, b[4:0]};  // word amount.
    case (req.instr_type)
        alu_pkg::ADD:    return a + b;
        alu_pkg::SUB:    return a - b;
        alu_pkg::ADDW:   return sext_word(aw + b[31:0]);
        alu_pkg::SUBW:   return sext_word(aw - b[31:0]);
        alu_pkg::SLT:    return {63'b0, $signed(a) < $signed(b)};
        alu_pkg::SLTU:   return {63'b0, a < b};
        alu_pkg::AND:    return a & b;
        alu_pkg::OR:     return a | b;
        alu_pkg::XOR:    return a ^ b;
        alu_pkg::ANDN:   return a & ~b;
        alu_pkg::ORN:    return a | ~b;
        alu_pkg::XNOR:   return ~(a ^ b);
        alu_pkg::SLL:    return a << sh;
        alu_pkg::SRL:    return a >> sh;
        alu_pkg::SRA:    return $signed(a) >>> sh;
        alu_pkg::SLLW:   return sext_word(aw << shw);
        alu_pkg::SRLW:   return sext_word(aw >> shw);
        alu_pkg::SRAW:   return sext_word($signed(aw) >>> shw);
        alu_pkg::SLLIUW: return {32'b0, aw} << sh;
        // a shift by the full width gives zero, so amount zero needs no special case
        alu_pkg::ROL:    return (a << sh) | (a >> (7'd64 - sh));
        alu_pkg::ROR:    return (a >> sh) | (a << (7'd64 - sh));
        alu_pkg::ROLW:   return sext_word((aw << shw) | (aw >> (6'd32 - shw)));
        alu_pkg::RORW:   return sext_word((aw >> shw) | (aw << (6'd32 - shw)));
        default:         return '0;
    endcase
endfunction

`endif

// File: test/tb_alu_top.sv
// testbench of the integer execution unit
// clock, reset, corner and random requests, downstream back-pressure,
// queue of expected responses, concurrent response checks.

`timescale 1ns/100ps
`default_nettype none

module tb_alu_top;

    logic               clk_i;
    logic               reset_i;
    logic               req_valid_i;
    logic               req_ready_o;
    alu_pkg::alu_req_t  req_i;
    logic               resp_valid_o;
    logic               resp_ready_i;
    alu_pkg::alu_resp_t resp_o;

    integer             seed;
    int                 stall_mode;  // 0 always ready, 1 random, 2 long stalls.
    int                 stall_left;
    logic               next_ready;
    logic               reset_q;
    int                 exp_count;
    alu_pkg::alu_resp_t exp_front;
    alu_pkg::alu_resp_t new_entry;
    alu_pkg::alu_resp_t exp_queue[$];

    `include "tb_alu_model.svh"

    alu_top dut0 (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_i        (req_i),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_o       (resp_o)
    );

    always #2 clk_i = ~clk_i;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    function automatic logic [5:0] amount_corner(input int sel);
        case (sel)
            0:       return 6'd0;
            1:       return 6'd31;
            2:       return 6'd32;
            default: return 6'd63;
        endcase
    endfunction

    function automatic alu_pkg::bus64_t value_corner(input int sel);
        case (sel)
            0:       return '0;
            1:       return '1;
            default: return 64'h8000_0000_0000_0000;
        endcase
    endfunction

    // ops cycle through all 23 kinds, the first rounds walk the corner amounts
    task automatic make_request(input int n, output alu_pkg::alu_req_t req);
        int k;
        k              = n / 23;
        req.instr_type = alu_pkg::instr_type_t'(5'(n % 23));
        req.data_rs1   = {$random(seed), $random(seed)};
        req.data_rs2   = {$random(seed), $random(seed)};
        req.tag        = 4'(n);
        if (k < 12) begin
            req.data_rs2[5:0] = amount_corner(k % 4);
            if (k / 4 != 0) req.data_rs1 = value_corner(k / 4);
        end else begin
            if ({$random(seed)} % 4 == 0) req.data_rs1 = value_corner({$random(seed)} % 3);
            if ({$random(seed)} % 4 == 0) req.data_rs2 = value_corner({$random(seed)} % 3);
        end
    endtask

    // ready is judged at the falling edge, where inputs and outputs are settled
    task automatic send_request(input alu_pkg::alu_req_t req);
        int waited;
        waited      = 0;
        req_i       = req;
        req_valid_i = 1'b1;
        @(negedge clk_i);
        while (!req_ready_o) begin
            waited++;
            if (waited > 100) report_failure("request not accepted within 100 cycles");
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #0.5;
        req_valid_i = 1'b0;
    endtask

    always @(negedge clk_i) begin
        if (stall_mode == 1) begin
            next_ready = {$random(seed)} % 2 == 0;
        end else if (stall_mode == 2) begin
            if (stall_left > 0) stall_left--;
            else if ({$random(seed)} % 4 == 0) stall_left = 1 + {$random(seed)} % 8;
            next_ready = (stall_left == 0);
        end else begin
            next_ready = 1'b1;
        end
    end

    always @(posedge clk_i) begin
        #0.5;
        resp_ready_i = next_ready;
    end

    // scoreboard. pop on consume, push the model result on accept.
    always @(posedge clk_i) begin
        reset_q <= reset_i;
        if (!reset_i) begin
            if (resp_valid_o && resp_ready_i && exp_queue.size() > 0) begin
                void'(exp_queue.pop_front());
            end
            if (req_valid_i && req_ready_o) begin
                new_entry.result = model_result(req_i);
                new_entry.tag    = req_i.tag;
                exp_queue.push_back(new_entry);
            end
        end
        exp_count = exp_queue.size();
        exp_front = (exp_count > 0) ? exp_queue[0] : '0;
    end

    reset_state_a: assert property (@(posedge clk_i) reset_q |-> !resp_valid_o && req_ready_o)
        else report_failure($sformatf("MISMATCH resp_valid_o/req_ready_o: got %h/%h expected 0/1",
                                      $sampled(resp_valid_o), $sampled(req_ready_o)));

    result_a: assert property (@(posedge clk_i) disable iff (reset_i)
        resp_valid_o && resp_ready_i |-> resp_o.result == exp_front.result)
        else report_failure($sformatf("MISMATCH resp_o.result: got %h expected %h",
                                      $sampled(resp_o.result), $sampled(exp_front.result)));

    tag_a: assert property (@(posedge clk_i) disable iff (reset_i)
        resp_valid_o && resp_ready_i |-> resp_o.tag == exp_front.tag)
        else report_failure($sformatf("MISMATCH resp_o.tag: got %h expected %h",
                                      $sampled(resp_o.tag), $sampled(exp_front.tag)));

    pending_a: assert property (@(posedge clk_i) disable iff (reset_i)
        resp_valid_o |-> exp_count > 0)
        else report_failure("response seen with no request outstanding");

    latency_a: assert property (@(posedge clk_i) disable iff (reset_i)
        req_valid_i && req_ready_o |=> resp_valid_o)
        else report_failure("no response one cycle after acceptance");

    stall_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o))
        else report_failure("response changed or vanished while stalled");

    stall_ready_a: assert property (@(posedge clk_i) disable iff (reset_i)
        resp_valid_o && !resp_ready_i |-> !req_ready_o)
        else report_failure($sformatf("MISMATCH req_ready_o: got %h expected 0",
                                      $sampled(req_ready_o)));

    initial begin
        alu_pkg::alu_req_t req;
        int                n;
        int                waited;
        seed         = 32'h6945;
        clk_i        = 1'b0;
        reset_i      = 1'b1;
        req_valid_i  = 1'b0;
        req_i        = '0;
        resp_ready_i = 1'b0;
        stall_mode   = 0;
        stall_left   = 0;
        next_ready   = 1'b1;
        repeat (16) @(posedge clk_i);
        #0.5;
        reset_i = 1'b0;
        for (n = 0; n < 2000; n++) begin
            case (n / 500)
                1:       stall_mode = 1;
                3:       stall_mode = 2;
                default: stall_mode = 0;
            endcase
            make_request(n, req);
            send_request(req);
        end
        stall_mode = 0;
        waited     = 0;
        @(negedge clk_i);
        while (exp_count != 0 || resp_valid_o) begin
            waited++;
            if (waited > 100) report_failure("responses not drained within 100 cycles");
            @(negedge clk_i);
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
design/alu_pkg.sv
design/alu_shift.sv
design/alu_arith.sv
design/alu_bitwise.sv
design/alu_result_stage.sv
design/alu_top.sv
+incdir+test
test/tb_alu_top.sv

// File: Makefile
# verilator build and run of the execution unit testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_alu_top -f sources.f
	./obj_dir/Vtb_alu_top | grep "sim passed"

clean:
	rm -rf obj_dir
